// File: rtl/centroidPkg.sv
package centroidPkg;

    ////////////////////////////////////////////////////////////////////////////
    // window geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int winSize = 7;
    // weight of line 0, last line gets the negated value
    localparam int halfWin = 3;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int pixW = 8;
    // 7 x 255 fits in 11 bits
    localparam int lineSumW = 11;
    // signed, covers +-12 x 1785
    localparam int momentW = 16;
    // 49 x 255
    localparam int massW = 14;
    localparam int cntW = 3;

    typedef logic [pixW-1:0] pixT;
    // pixel 0 in the low byte
    typedef pixT [winSize-1:0] lineT;
    // window[c][r] is column c, row r
    typedef lineT [winSize-1:0] windowT;
    typedef logic signed [momentW-1:0] momentT;
    typedef logic [massW-1:0] massT;

endpackage

// File: rtl/axisWeigher.sv
`timescale 1ns/1ps

module axisWeigher import centroidPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   start,
    input  windowT window,
    output logic   done,
    output momentT moment,
    output massT   mass
);

    logic [cntW-1:0] lineCnt;
    logic busy;
    logic lastStep;
    logic [lineSumW-1:0] lineSum;
    momentT weight;
    momentT lineSumS;
    momentT product;

    ////////////////////////////////////////////////////////////////////////////
    // line adder and weighting
    ////////////////////////////////////////////////////////////////////////////

    // sum of the pixels in the current line
    always_comb
    begin
        lineSum = '0;
        for (int i = 0; i < winSize; i++)
        begin
            lineSum = lineSum + lineSumW'(window[lineCnt][i]);
        end
    end

    // +halfWin for line 0 down to -halfWin for the last one
    assign weight = momentT'(halfWin) - momentT'(lineCnt);
    assign lineSumS = momentT'(lineSum);
    assign product = weight * lineSumS;

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            busy <= 1'b0;
            lineCnt <= '0;
            lastStep <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            // one extra stage so done trails the last line by a cycle
            done <= lastStep;
            lastStep <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                lineCnt <= '0;
            end
            else if (busy)
            begin
                if (lineCnt == cntW'(winSize - 1))
                begin
                    busy <= 1'b0;
                    lastStep <= 1'b1;
                end
                else
                begin
                    lineCnt <= lineCnt + 1'b1;
                end
            end
        end
    end

    // accumulators, held once busy drops
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            moment <= '0;
            mass <= '0;
        end
        else if (busy)
        begin
            moment <= moment + product;
            mass <= mass + massT'(lineSum);
        end
    end

endmodule

// File: rtl/momentCombiner.sv
`timescale 1ns/1ps

module momentCombiner import centroidPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   req,
    input  logic   maskIn,
    input  logic   colDone,
    input  momentT colMoment,
    input  momentT rowMoment,
    input  massT   colMass,
    output logic   start,
    output logic   ack,
    output momentT colResult,
    output momentT rowResult,
    output massT   mass,
    output logic   maskOut
);

    typedef enum logic [1:0]
    {
        stIdle,
        stBusy,
        stAck
    } stateT;

    stateT state;
    logic capture;

    // results land on the same edge that raises ack
    assign capture = (state == stBusy) && colDone;

    ////////////////////////////////////////////////////////////////////////////
    // handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= stIdle;
            start <= 1'b0;
            ack <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                stIdle:
                begin
                    if (req)
                    begin
                        start <= 1'b1;
                        state <= stBusy;
                    end
                end
                stBusy:
                begin
                    if (colDone)
                    begin
                        ack <= 1'b1;
                        state <= stAck;
                    end
                end
                stAck:
                begin
                    // requester may hold req as long as it likes
                    if (!req)
                    begin
                        ack <= 1'b0;
                        state <= stIdle;
                    end
                end
                default:
                begin
                    state <= stIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result registers
    ////////////////////////////////////////////////////////////////////////////

    // maskIn is still stable here, requester holds it until ack
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            colResult <= '0;
            rowResult <= '0;
            mass <= '0;
            maskOut <= 1'b0;
        end
        else if (capture)
        begin
            colResult <= colMoment;
            rowResult <= rowMoment;
            mass <= colMass;
            maskOut <= maskIn;
        end
    end

endmodule

// File: rtl/centroidTop.sv
`timescale 1ns/1ps

module centroidTop import centroidPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   req,
    input  windowT pixWindow,
    input  logic   maskIn,
    output logic   ack,
    output momentT colMoment,
    output momentT rowMoment,
    output massT   mass,
    output logic   maskOut
);

    logic start;
    logic colDone;
    momentT colEngMoment;
    momentT rowEngMoment;
    massT colEngMass;
    windowT rowWindow;

    // transpose so the row engine walks rows as its lines
    genvar r, c;
    generate
        for (r = 0; r < winSize; r++)
        begin : genRow
            for (c = 0; c < winSize; c++)
            begin : genCol
                assign rowWindow[r][c] = pixWindow[c][r];
            end
        end
    endgenerate

    ////////////////////////////////////////////////////////////////////////////
    // engines
    ////////////////////////////////////////////////////////////////////////////

    axisWeigher colWeigher
    (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .window (pixWindow),
        .done   (colDone),
        .moment (colEngMoment),
        .mass   (colEngMass)
    );

    // finishes on the same edge as colWeigher, mass is the same too
    axisWeigher rowWeigher
    (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .window (rowWindow),
        .done   (),
        .moment (rowEngMoment),
        .mass   ()
    );

    momentCombiner combiner
    (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .maskIn    (maskIn),
        .colDone   (colDone),
        .colMoment (colEngMoment),
        .rowMoment (rowEngMoment),
        .colMass   (colEngMass),
        .start     (start),
        .ack       (ack),
        .colResult (colMoment),
        .rowResult (rowMoment),
        .mass      (mass),
        .maskOut   (maskOut)
    );

endmodule

// File: dv/centroidTop_properties.sv
`timescale 1ns/1ps

module centroidTop_properties import centroidPkg::*;
(
    input logic   clk,
    input logic   rstN,
    input logic   req,
    input logic   ack,
    input momentT colMoment,
    input momentT rowMoment,
    input massT   mass,
    input logic   maskOut
);

    // sync reset clears handshake and result registers
    resetClears: assert property (@(posedge clk)
        !rstN |=> !ack && colMoment == '0 && rowMoment == '0 && mass == '0 && !maskOut)
        else $error("reset did not clear ack and the results");

    // ack set on the 10th edge after req sampled, seen one sample later
    ackLatency: assert property (@(posedge clk) disable iff (!rstN)
        $rose(req) && !ack |-> ##11 $rose(ack))
        else $error("ack did not rise 10 edges after the request");

    ackFall: assert property (@(posedge clk) disable iff (!rstN)
        ack && !req |=> !ack)
        else $error("ack did not fall one edge after req dropped");

    resultsHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack && $past(ack) |-> $stable(colMoment) && $stable(rowMoment)
            && $stable(mass) && $stable(maskOut))
        else $error("results changed while ack was high");

    noAckWithoutReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

endmodule

bind centroidTop centroidTop_properties props0
(
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .ack       (ack),
    .colMoment (colMoment),
    .rowMoment (rowMoment),
    .mass      (mass),
    .maskOut   (maskOut)
);

// File: dv/centroidTb.sv
`timescale 1ns/1ps

module centroidTb import centroidPkg::*;
();

    logic clk;
    logic rstN;
    logic req;
    windowT pixWindow;
    logic maskIn;
    logic ack;
    momentT colMoment;
    momentT rowMoment;
    massT mass;
    logic maskOut;

    integer seed;
    logic maskBit;

    always #20 clk = ~clk;

    centroidTop dut0
    (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .pixWindow (pixWindow),
        .maskIn    (maskIn),
        .ack       (ack),
        .colMoment (colMoment),
        .rowMoment (rowMoment),
        .mass      (mass),
        .maskOut   (maskOut)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic expectEqual(input logic signed [31:0] got, input logic signed [31:0] exp,
                               input string what);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkOutputs(input int expCol, input int expRow, input int expMass,
                                input logic expMask);
        expectEqual(32'(colMoment), expCol, "colMoment");
        expectEqual(32'(rowMoment), expRow, "rowMoment");
        expectEqual(32'(mass), expMass, "mass");
        expectEqual(32'(maskOut), 32'(expMask), "maskOut");
    endtask

    // weights run from +halfWin on line 0 to -halfWin on the last line
    task automatic referenceModel(input windowT w, output int expCol, output int expRow,
                                  output int expMass);
        int p;
        expCol = 0;
        expRow = 0;
        expMass = 0;
        for (int c = 0; c < winSize; c++)
        begin
            for (int r = 0; r < winSize; r++)
            begin
                p = int'(w[c][r]);
                expCol += (halfWin - c) * p;
                expRow += (halfWin - r) * p;
                expMass += p;
            end
        end
    endtask

    // sampled on the falling edge, away from the DUT's update edge
    task automatic waitAck(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < 40)
        begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level)
        begin
            $display("Timeout: ack did not reach %0b within 40 cycles at %0t ns", level, $time);
            $display("SIMULATION FAILED");
            $fatal(1, "handshake timeout");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one full four-phase transfer
    ////////////////////////////////////////////////////////////////////////////

    task automatic runRequest(input windowT w, input int hold);
        int expCol;
        int expRow;
        int expMass;
        logic m;
        m = maskBit;
        maskBit = ~maskBit;
        referenceModel(w, expCol, expRow, expMass);
        @(posedge clk);
        req <= 1'b1;
        pixWindow <= w;
        maskIn <= m;
        waitAck(1'b1);
        checkOutputs(expCol, expRow, expMass, m);
        // back-pressure, req held past ack
        repeat (hold)
        begin
            @(negedge clk);
            expectEqual(32'(ack), 1, "ack under back-pressure");
            checkOutputs(expCol, expRow, expMass, m);
        end
        @(posedge clk);
        req <= 1'b0;
        // inputs are free again once ack is seen
        pixWindow <= ~w;
        maskIn <= ~m;
        waitAck(1'b0);
        checkOutputs(expCol, expRow, expMass, m);
    endtask

    initial
    begin
        windowT w;
        int vals[3];
        int rows[5];
        int cols[5];
        int hold;
        seed = 32'hed30;
        maskBit = 1'b0;
        clk = 1'b0;
        rstN = 1'b0;
        req = 1'b0;
        pixWindow = '0;
        maskIn = 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        expectEqual(32'(ack), 0, "ack after reset");
        checkOutputs(0, 0, 0, 1'b0);

        // uniform windows
        vals = '{0, 1, 255};
        foreach (vals[i])
        begin
            for (int c = 0; c < winSize; c++)
            begin
                for (int r = 0; r < winSize; r++)
                begin
                    w[c][r] = pixT'(vals[i]);
                end
            end
            runRequest(w, 0);
        end

        // single bright pixel at the corners and the center
        rows = '{0, 0, winSize - 1, winSize - 1, halfWin};
        cols = '{0, winSize - 1, 0, winSize - 1, halfWin};
        foreach (rows[k])
        begin
            w = '0;
            w[cols[k]][rows[k]] = pixT'(255);
            runRequest(w, 0);
        end

        ////////////////////////////////////////////////////////////////////////
        // random windows with random back-pressure
        ////////////////////////////////////////////////////////////////////////

        for (int n = 0; n < 20; n++)
        begin
            for (int c = 0; c < winSize; c++)
            begin
                for (int r = 0; r < winSize; r++)
                begin
                    w[c][r] = pixT'($random(seed));
                end
            end
            hold = $random(seed) & 15;
            runRequest(w, hold);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: compile.f
rtl/centroidPkg.sv
rtl/axisWeigher.sv
rtl/momentCombiner.sv
rtl/centroidTop.sv
dv/centroidTop_properties.sv
dv/centroidTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the centroid testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module centroidTb -f compile.f 2>&1 | tee sim.log \
    && ./obj_dir/VcentroidTb 2>&1 | tee -a sim.log \
    || echo "build or simulation returned an error" | tee -a sim.log

grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
